// File: filelist.f
+incdir+verif
hdl/gomoku_pkg.sv
hdl/window_scanner.sv
hdl/pattern_matcher.sv
hdl/score_accumulator.sv
hdl/gomoku_eval_top.sv
verif/tb_gomoku_eval.sv

// File: Bender.yml
package:
  name: gomoku_eval

sources:
  - hdl/gomoku_pkg.sv
  - hdl/window_scanner.sv
  - hdl/pattern_matcher.sv
  - hdl/score_accumulator.sv
  - hdl/gomoku_eval_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_gomoku_eval.sv

// File: verif/tb_eval_model.svh
// gomoku reference model, scores a board window by window and steps a galois lfsr
`ifndef TB_EVAL_MODEL_SVH
`define TB_EVAL_MODEL_SVH

// one window character for a color, X stone, o empty, - anything else
function automatic string stone_char(cell_t v, cell_t color);
    if (v == color) return "X";
    if (v == CELL_EMPTY) return "o";
    return "-";
endfunction

function automatic int pattern_value(string s);
    case (s)
        "XXXXX":                   return W_FIVE;
        "oXXXo":                   return W_THREE;
        "oXoXo":                   return W_TWO;
        "XoXXX", "XXXoX", "XXoXX": return W_BLOCKED_FOUR;
        "XooXX", "XXooX", "XoXoX": return W_BLOCKED_THREE;
        "XoooX":                   return W_BLOCKED_TWO;
        default:                   return 0;
    endcase
endfunction

// black total minus white total over rows, columns and both diagonals
function automatic score_t model_score(board_t b);
    longint black_total;
    longint white_total;
    int     dr;
    int     dc;
    int     row_last;
    int     col_last;
    int     rr;
    int     cc;
    string  sb;
    string  sw;
    black_total = 0;
    white_total = 0;
    for (int d = 0; d < 4; d++) begin
        dr       = (d == 0) ? 0 : 1;
        dc       = (d == 1) ? 0 : ((d == 3) ? -1 : 1);
        row_last = (d == 0) ? BOARD_DIM - 1 : WIN_SPAN - 1;
        col_last = (d == 1) ? BOARD_DIM - 1 : WIN_SPAN - 1;
        for (int r = 0; r <= row_last; r++) begin
            for (int c = 0; c <= col_last; c++) begin
                sb = "";
                sw = "";
                for (int k = 0; k < WIN_LEN; k++) begin
                    rr = r + k * dr;
                    cc = c + k * dc + ((d == 3) ? WIN_LEN - 1 : 0);   // down-left starts at c+4
                    sb = {sb, stone_char(b[rr * BOARD_DIM + cc], CELL_BLACK)};
                    sw = {sw, stone_char(b[rr * BOARD_DIM + cc], CELL_WHITE)};
                end
                black_total += pattern_value(sb);
                white_total += pattern_value(sw);
            end
        end
    end
    return score_t'(black_total - white_total);
endfunction

// galois form, taps x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(logic [15:0] s);
    if (s[0]) return (s >> 1) ^ 16'hB400;
    return s >> 1;
endfunction

`endif

// File: verif/tb_gomoku_eval.sv
// testbench for the gomoku board evaluator, directed and random boards against a model
`default_nettype none
`timescale 1ns/10ps

module tb_gomoku_eval import gomoku_pkg::*; ();

    `include "tb_eval_model.svh"

    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        rst_n;
    logic        board_valid;
    board_t      board;
    logic        board_ready;
    logic        score_valid;
    score_t      score;
    logic        score_ready;
    logic [15:0] lfsr_q;
    int          mismatch_count = 0;
    int          timeout_count = 0;
    string       patterns [10] = '{"XXXXX", "oXXXo", "oXoXo", "XoXXX", "XXXoX",
                                   "XXoXX", "XooXX", "XXooX", "XoXoX", "XoooX"};

    gomoku_eval_top DUT (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_board_valid_i (board_valid),
        .i_board_i       (board),
        .o_board_ready_o (board_ready),
        .o_score_valid_o (score_valid),
        .o_score_o       (score),
        .i_score_ready_i (score_ready)
    );

    always #4 clk = ~clk;

    task automatic check_score(string name, score_t exp, score_t act);
        if (exp !== act) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(string name, string what);
        $display("timeout in %s: %s within %0d cycles", name, what, TIMEOUT_CYCLES);
        timeout_count++;
    endtask

    function automatic board_t empty_board();
        board_t b;
        for (int i = 0; i < BOARD_DIM * BOARD_DIM; i++) begin
            b[i] = CELL_EMPTY;
        end
        return b;
    endfunction

    // lays a pattern string from (r, c) stepping by (dr, dc)
    task automatic put_line(inout board_t b, input int r, input int c, input int dr,
                            input int dc, input string pat, input cell_t color);
        for (int k = 0; k < pat.len(); k++) begin
            b[(r + k * dr) * BOARD_DIM + c + k * dc] = (pat[k] == "X") ? color : CELL_EMPTY;
        end
    endtask

    task automatic send_board(input string name, input board_t b, output logic ok);
        int cycles;
        cycles = 0;
        board = b;
        board_valid = 1'b1;
        while (!board_ready && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        ok = board_ready;
        if (!ok) begin
            report_timeout(name, "board was never accepted");
        end
        @(negedge clk);   // taken on the rising edge just passed
        board_valid = 1'b0;
    endtask

    task automatic wait_score(input string name, output logic ok);
        int cycles;
        cycles = 0;
        while (!score_valid && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        ok = score_valid;
        if (!ok) begin
            report_timeout(name, "no score came back");
        end
    endtask

    task automatic take_score();
        score_ready = 1'b1;
        @(negedge clk);
        score_ready = 1'b0;
    endtask

    task automatic score_board(string name, board_t b);
        logic ok;
        send_board(name, b, ok);
        if (ok) begin
            wait_score(name, ok);
        end
        if (ok) begin
            check_score(name, model_score(b), score);
            take_score();
            check_flag({name, " valid cleared"}, 1'b0, score_valid);
            check_flag({name, " ready again"}, 1'b1, board_ready);
        end
    endtask

    task automatic reset_then_empty();
        check_flag("reset score valid", 1'b0, score_valid);
        check_flag("reset board ready", 1'b1, board_ready);
        score_board("empty board", empty_board());
    endtask

    task automatic single_fives();
        board_t b;
        b = empty_board();
        put_line(b, 7, 3, 0, 1, "XXXXX", CELL_BLACK);
        check_score("model black five", score_t'(W_FIVE), model_score(b));
        score_board("black five row", b);
        b = empty_board();
        put_line(b, 2, 9, 1, 0, "XXXXX", CELL_WHITE);
        check_score("model white five", -score_t'(W_FIVE), model_score(b));
        score_board("white five column", b);
    endtask

    task automatic every_pattern();
        board_t b;
        cell_t  color;
        for (int p = 0; p < 10; p++) begin
            for (int d = 0; d < 4; d++) begin
                for (int n = 0; n < 2; n++) begin
                    b = empty_board();
                    color = (n == 0) ? CELL_BLACK : CELL_WHITE;
                    case (d)
                        0:       put_line(b, 6, 4, 0, 1, patterns[p], color);
                        1:       put_line(b, 4, 6, 1, 0, patterns[p], color);
                        2:       put_line(b, 4, 4, 1, 1, patterns[p], color);
                        default: put_line(b, 4, 10, 1, -1, patterns[p], color);
                    endcase
                    score_board($sformatf("pattern %s dir %0d color %0d", patterns[p], d,
                                          color), b);
                end
            end
        end
    endtask

    task automatic random_boards();
        board_t     b;
        logic [1:0] v;
        for (int n = 0; n < 20; n++) begin
            for (int i = 0; i < BOARD_DIM * BOARD_DIM; i++) begin
                for (int j = 0; j < 2; j++) begin
                    v[j] = lfsr_q[0];
                    lfsr_q = lfsr_step(lfsr_q);
                end
                b[i] = (v == 2'd3) ? CELL_EMPTY : cell_t'(v);
            end
            score_board($sformatf("random board %0d", n), b);
        end
    endtask

    task automatic back_pressure();
        board_t first;
        board_t second;
        score_t held;
        logic   ok;
        first = empty_board();
        put_line(first, 0, 0, 1, 1, "XoXXX", CELL_BLACK);
        second = empty_board();
        put_line(second, 10, 14, 1, -1, "oXXXo", CELL_WHITE);   // bottom right corner
        send_board("back pressure first", first, ok);
        if (ok) begin
            wait_score("back pressure first", ok);
        end
        if (ok) begin
            held = score;
            check_score("back pressure first", model_score(first), held);
            board = second;
            board_valid = 1'b1;   // offered while the score waits
            repeat (50) begin
                @(negedge clk);
                check_score("back pressure hold", held, score);
                check_flag("back pressure valid", 1'b1, score_valid);
                check_flag("back pressure ready", 1'b0, board_ready);
            end
            take_score();
        end
        score_board("back pressure second", second);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        board_valid = 1'b0;
        board = '0;
        score_ready = 1'b0;
        lfsr_q = 16'd82;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_then_empty();
        single_fives();
        every_pattern();
        random_boards();
        back_pressure();
        finish_run();
    end

endmodule

`default_nettype wire

// File: hdl/gomoku_eval_top.sv
// gomoku board evaluator top, scanner feeding matcher feeding accumulator
`default_nettype none
`timescale 1ns/10ps

module gomoku_eval_top import gomoku_pkg::*; (
    input  wire logic    i_clk,
    input  wire logic    i_rst_n,
    input  wire logic    i_board_valid_i,
    input  wire board_t  i_board_i,
    output logic         o_board_ready_o,
    output logic         o_score_valid_o,
    output score_t       o_score_o,
    input  wire logic    i_score_ready_i
);

    window_t win;
    logic    win_valid;
    match_t  match;
    logic    match_valid;
    logic    busy;

    window_scanner u_scanner (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_board_valid_i (i_board_valid_i),
        .i_board_i       (i_board_i),
        .o_board_ready_o (o_board_ready_o),
        .i_busy_i        (busy),
        .o_win_valid_o   (win_valid),
        .o_win_o         (win)
    );

    pattern_matcher u_matcher (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_win_valid_i   (win_valid),
        .i_win_i         (win),
        .o_match_valid_o (match_valid),
        .o_match_o       (match)
    );

    score_accumulator u_accumulator (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_match_valid_i (match_valid),
        .i_match_i       (match),
        .i_score_ready_i (i_score_ready_i),
        .o_score_valid_o (o_score_valid_o),
        .o_score_o       (o_score_o),
        .o_busy_o        (busy)
    );

endmodule

`default_nettype wire

// File: hdl/score_accumulator.sv
// score accumulator, sums match weights and returns black minus white on a handshake
`default_nettype none
`timescale 1ns/10ps

module score_accumulator import gomoku_pkg::*; (
    input  wire logic    i_clk,
    input  wire logic    i_rst_n,
    input  wire logic    i_match_valid_i,
    input  wire match_t  i_match_i,
    input  wire logic    i_score_ready_i,
    output logic         o_score_valid_o,
    output score_t       o_score_o,
    output logic         o_busy_o
);

    score_t black_sum_q;
    score_t white_sum_q;
    score_t black_next;
    score_t white_next;
    logic   score_taken;

    assign black_next  = black_sum_q + $signed(i_match_i.black);
    assign white_next  = white_sum_q + $signed(i_match_i.white);
    assign score_taken = o_score_valid_o && i_score_ready_i;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            black_sum_q     <= '0;
            white_sum_q     <= '0;
            o_score_o       <= '0;
            o_score_valid_o <= 1'b0;
            o_busy_o        <= 1'b0;
        end else begin
            if (score_taken) begin
                o_score_valid_o <= 1'b0;
                o_busy_o        <= 1'b0;
            end else if (i_match_valid_i) begin
                o_busy_o <= 1'b1;   // held until the score is consumed
            end
            if (i_match_valid_i) begin
                if (i_match_i.last) begin
                    o_score_o       <= black_next - white_next;
                    o_score_valid_o <= 1'b1;
                    black_sum_q     <= '0;   // ready for the next board
                    white_sum_q     <= '0;
                end else begin
                    black_sum_q <= black_next;
                    white_sum_q <= white_next;
                end
            end
        end
    end

    a_score_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_score_valid_o && !i_score_ready_i |=> o_score_valid_o && $stable(o_score_o));

    // the scanner must not start a new board while a score waits
    a_no_match_waiting: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_score_valid_o |-> !i_match_valid_i);

endmodule

`default_nettype wire

// File: hdl/pattern_matcher.sv
// pattern matcher, looks up the black and white weight of one window per cycle
`default_nettype none
`timescale 1ns/10ps

module pattern_matcher import gomoku_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_rst_n,
    input  wire logic     i_win_valid_i,
    input  wire window_t  i_win_i,
    output logic          o_match_valid_o,
    output match_t        o_match_o
);

    weight_t black_wt;
    weight_t white_wt;

    // weight of the window for one color, masks read first cell to fifth
    function automatic weight_t pattern_weight(window_t w, cell_t color);
        mask_t   stone;
        mask_t   empty;
        weight_t wt;
        for (int k = 0; k < WIN_LEN; k++) begin
            stone[WIN_LEN-1-k] = (w.cells[k] == color);
            empty[WIN_LEN-1-k] = (w.cells[k] == CELL_EMPTY);
        end
        wt = '0;
        // every cell must be this color or empty
        if (empty == ~stone) begin
            case (stone)
                5'b11111: wt = W_FIVE;
                5'b01110: wt = W_THREE;
                5'b01010: wt = W_TWO;
                5'b10111,
                5'b11101,
                5'b11011: wt = W_BLOCKED_FOUR;
                5'b10011,
                5'b11001,
                5'b10101: wt = W_BLOCKED_THREE;
                5'b10001: wt = W_BLOCKED_TWO;
                default:  wt = '0;
            endcase
        end
        return wt;
    endfunction

    assign black_wt = pattern_weight(i_win_i, CELL_BLACK);
    assign white_wt = pattern_weight(i_win_i, CELL_WHITE);

    always_ff @(posedge i_clk) begin
        if (i_win_valid_i) begin
            o_match_o.black <= black_wt;
            o_match_o.white <= white_wt;
            o_match_o.last  <= i_win_i.last;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_match_valid_o <= 1'b0;
        end else begin
            o_match_valid_o <= i_win_valid_i;
        end
    end

    a_one_color: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_match_valid_o |-> (o_match_o.black == '0) || (o_match_o.white == '0));

endmodule

`default_nettype wire

// File: hdl/window_scanner.sv
// window scanner, captures a board and issues every five-cell window one per cycle
`default_nettype none
`timescale 1ns/10ps

module window_scanner import gomoku_pkg::*; (
    input  wire logic    i_clk,
    input  wire logic    i_rst_n,
    input  wire logic    i_board_valid_i,
    input  wire board_t  i_board_i,
    output logic         o_board_ready_o,
    input  wire logic    i_busy_i,
    output logic         o_win_valid_o,
    output window_t      o_win_o
);

    typedef enum logic {
        ST_IDLE,
        ST_SCAN
    } scan_state_t;

    scan_state_t state_q;
    dir_t        dir_q;
    coord_t      row_q;
    coord_t      col_q;
    coord_t      row_max;
    coord_t      col_max;
    logic        row_end;
    logic        col_end;
    logic        scan_end;
    board_t      board_q;
    window_t     win_d;

    // cell k of the window starting at (r, c) in direction d
    function automatic cell_t cell_at(board_t b, dir_t d, coord_t r, coord_t c, int k);
        int rr;
        int cc;
        rr = int'(r);
        cc = int'(c);
        case (d)
            DIR_ROW: cc = cc + k;
            DIR_COL: rr = rr + k;
            DIR_DIAG_DR: begin
                rr = rr + k;
                cc = cc + k;
            end
            default: begin
                rr = rr + k;
                cc = cc + WIN_LEN - 1 - k;   // down-left walks back along the row
            end
        endcase
        return b[rr * BOARD_DIM + cc];
    endfunction

    assign row_max  = (dir_q == DIR_ROW) ? coord_t'(BOARD_DIM - 1) : coord_t'(WIN_SPAN - 1);
    assign col_max  = (dir_q == DIR_COL) ? coord_t'(BOARD_DIM - 1) : coord_t'(WIN_SPAN - 1);
    assign row_end  = (row_q == row_max);
    assign col_end  = (col_q == col_max);
    assign scan_end = row_end && col_end && (dir_q == DIR_DIAG_DL);

    assign o_board_ready_o = (state_q == ST_IDLE) && !i_busy_i;

    always_comb begin
        win_d.last = scan_end;
        for (int k = 0; k < WIN_LEN; k++) begin
            win_d.cells[k] = cell_at(board_q, dir_q, row_q, col_q, k);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_board_valid_i && o_board_ready_o) begin
            board_q <= i_board_i;
        end
        if (state_q == ST_SCAN) begin
            o_win_o <= win_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q       <= ST_IDLE;
            dir_q         <= DIR_ROW;
            row_q         <= '0;
            col_q         <= '0;
            o_win_valid_o <= 1'b0;
        end else begin
            o_win_valid_o <= (state_q == ST_SCAN);
            case (state_q)
                ST_IDLE: begin
                    if (i_board_valid_i && o_board_ready_o) begin
                        state_q <= ST_SCAN;
                        dir_q   <= DIR_ROW;
                        row_q   <= '0;
                        col_q   <= '0;
                    end
                end
                default: begin
                    if (!col_end) begin
                        col_q <= col_q + 4'd1;
                    end else begin
                        col_q <= '0;
                        if (!row_end) begin
                            row_q <= row_q + 4'd1;
                        end else begin
                            row_q <= '0;
                            case (dir_q)
                                DIR_ROW:     dir_q <= DIR_COL;
                                DIR_COL:     dir_q <= DIR_DIAG_DR;
                                DIR_DIAG_DR: dir_q <= DIR_DIAG_DL;
                                default: begin
                                    dir_q   <= DIR_ROW;
                                    state_q <= ST_IDLE;   // all 572 windows issued
                                end
                            endcase
                        end
                    end
                end
            endcase
        end
    end

    // in idle only the final window of a board can still be leaving
    a_idle_only_last: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_win_valid_o && (state_q == ST_IDLE) |-> o_win_o.last);

    a_coord_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state_q == ST_SCAN) |-> (row_q <= row_max) && (col_q <= col_max));

endmodule

`default_nettype wire

// File: hdl/gomoku_pkg.sv
// gomoku evaluator shared types, board geometry and pattern weights
`default_nettype none

package gomoku_pkg;

    localparam int BOARD_DIM = 15;
    localparam int WIN_LEN   = 5;
    localparam int WIN_SPAN  = BOARD_DIM - WIN_LEN + 1;   // start positions along one axis

    // one board cell, value 3 is illegal
    typedef logic [1:0] cell_t;

    localparam cell_t CELL_BLACK = 2'd0;
    localparam cell_t CELL_WHITE = 2'd1;
    localparam cell_t CELL_EMPTY = 2'd2;

    // cell (r, c) sits at index r * BOARD_DIM + c
    typedef cell_t [BOARD_DIM*BOARD_DIM-1:0] board_t;

    typedef logic [3:0]         coord_t;     // row or column counter
    typedef logic [WIN_LEN-1:0] mask_t;      // one bit per window cell, first cell in msb
    typedef logic [31:0]        weight_t;
    typedef logic signed [31:0] score_t;

    typedef enum logic [1:0] {
        DIR_ROW,
        DIR_COL,
        DIR_DIAG_DR,
        DIR_DIAG_DL
    } dir_t;

    typedef struct packed {
        logic                      last;    // final window of the board
        cell_t [WIN_LEN-1:0]       cells;   // cells[0] is the first cell
    } window_t;

    typedef struct packed {
        logic    last;
        weight_t black;
        weight_t white;
    } match_t;

    localparam weight_t W_FIVE          = 32'd1000000;
    localparam weight_t W_THREE         = 32'd1000;
    localparam weight_t W_TWO           = 32'd100;
    localparam weight_t W_BLOCKED_FOUR  = 32'd10000;
    localparam weight_t W_BLOCKED_THREE = 32'd100;
    localparam weight_t W_BLOCKED_TWO   = 32'd10;

endpackage

`default_nettype wire
